/* source/biq_pkg.sv */
`default_nettype none

package biq_pkg;

   ////////////////////
   // Word geometry
   ////////////////////

   // A word is ten decimal digits, each one a seven bit bi-quinary code
   localparam int WORD_DIGITS = 10;
   localparam int BIQ_W       = 7;

   // Code bits run bi0, bi5, q0, q1, q2, q3, q4 from the top bit down
   typedef logic [BIQ_W-1:0]             biq_t;
   typedef logic [9:0]                   key_t;
   typedef logic [WORD_DIGITS*BIQ_W-1:0] biq_word_t;
   typedef logic [3:0]                   digit_pos_t;
   typedef logic [2:0]                   op_t;

   // Position of the most significant digit, the last one processed
   localparam digit_pos_t LAST_DIGIT_POS = digit_pos_t'(WORD_DIGITS - 1);

   ////////////////////
   // Digit codes
   ////////////////////

   localparam biq_t BIQ_0     = 7'b10_10000;
   localparam biq_t BIQ_1     = 7'b10_01000;
   localparam biq_t BIQ_2     = 7'b10_00100;
   localparam biq_t BIQ_3     = 7'b10_00010;
   localparam biq_t BIQ_4     = 7'b10_00001;
   localparam biq_t BIQ_5     = 7'b01_10000;
   localparam biq_t BIQ_6     = 7'b01_01000;
   localparam biq_t BIQ_7     = 7'b01_00100;
   localparam biq_t BIQ_8     = 7'b01_00010;
   localparam biq_t BIQ_9     = 7'b01_00001;
   // No bit set in either group
   localparam biq_t BIQ_BLANK = 7'b00_00000;

   ////////////////////
   // Operations
   ////////////////////

   localparam op_t OP_ADD       = 3'd0;
   localparam op_t OP_SUB       = 3'd1;
   localparam op_t OP_SHIFT_ADD = 3'd2;
   localparam op_t OP_RESET_ADD = 3'd3;
   localparam op_t OP_ADD_KEY   = 3'd4;

   // Sequencer states
   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_RUN,
      SEQ_FINISH
   } seq_state_t;

endpackage

`default_nettype wire

/* source/biq_9s_comp.sv */
`timescale 1ns/100ps
`default_nettype none

module biq_9s_comp import biq_pkg::*; (
   input  wire biq_t digit,
   output biq_t      compl
);

   // Nines complement by table lookup
   // Only the ten legal codes are listed, so a blank or a malformed code
   // turns into blank and is caught later by the digit adder check
   always_comb begin
      case (digit)
         BIQ_0:   compl = BIQ_9;
         BIQ_1:   compl = BIQ_8;
         BIQ_2:   compl = BIQ_7;
         BIQ_3:   compl = BIQ_6;
         BIQ_4:   compl = BIQ_5;
         BIQ_5:   compl = BIQ_4;
         BIQ_6:   compl = BIQ_3;
         BIQ_7:   compl = BIQ_2;
         BIQ_8:   compl = BIQ_1;
         BIQ_9:   compl = BIQ_0;
         default: compl = BIQ_BLANK;
      endcase
   end

endmodule

`default_nettype wire

/* source/add_in_b.sv */
`timescale 1ns/100ps
`default_nettype none

module add_in_b import biq_pkg::*; (
   input  wire biq_t dist_early,
   input  wire biq_t dist_ontime,
   input  wire key_t key,
   input  wire       key_gate,
   input  wire       ontime_add_gate,
   input  wire       compl_add_gate,
   input  wire       dist_valid,
   input  wire       dist_not_blank,
   input  wire       zero_entry,
   input  wire       true_add_gate,
   output biq_t      entry_b
);

   biq_t key_biq;
   biq_t dist_compl;
   logic dist_true_add;
   logic dist_compl_add;

   // Console key, one line per decimal digit with bit 0 for zero
   // More than one key down, or none, reads as blank
   always_comb begin
      if (key_gate) begin
         case (key)
            10'b00_0000_0001: key_biq = BIQ_0;
            10'b00_0000_0010: key_biq = BIQ_1;
            10'b00_0000_0100: key_biq = BIQ_2;
            10'b00_0000_1000: key_biq = BIQ_3;
            10'b00_0001_0000: key_biq = BIQ_4;
            10'b00_0010_0000: key_biq = BIQ_5;
            10'b00_0100_0000: key_biq = BIQ_6;
            10'b00_1000_0000: key_biq = BIQ_7;
            10'b01_0000_0000: key_biq = BIQ_8;
            10'b10_0000_0000: key_biq = BIQ_9;
            default:          key_biq = BIQ_BLANK;
         endcase
      end else begin
         key_biq = BIQ_BLANK;
      end
   end

   biq_9s_comp comp_i (
      .digit (dist_early),
      .compl (dist_compl)
   );

   // A bad distributor digit drops the true and complement paths
   assign dist_true_add  = true_add_gate & dist_valid & dist_not_blank;
   assign dist_compl_add = compl_add_gate & dist_valid & dist_not_blank;

   // Zero entry wins over everything, the key path is the last resort
   assign entry_b = zero_entry      ? BIQ_0
                  : dist_true_add   ? dist_early
                  : dist_compl_add  ? dist_compl
                  : ontime_add_gate ? dist_ontime
                  :                   key_biq;

endmodule

`default_nettype wire

/* source/biq_digit_adder.sv */
`timescale 1ns/100ps
`default_nettype none

module biq_digit_adder import biq_pkg::*; (
   input  wire biq_t a,
   input  wire biq_t b,
   input  wire       acc_zero,
   input  wire       carry_in,
   output biq_t      sum,
   output logic      carry_out,
   output logic      digit_error
);

   // A code is legal with exactly one bi bit and exactly one quinary bit
   function automatic logic code_ok(input biq_t d);
      return $onehot(d[6:5]) && $onehot(d[4:0]);
   endfunction

   // Quinary group to its count 0 to 4, with q0 in the top bit
   function automatic logic [2:0] quin_value(input logic [4:0] q);
      logic [2:0] v;
      case (q)
         5'b10000: v = 3'd0;
         5'b01000: v = 3'd1;
         5'b00100: v = 3'd2;
         5'b00010: v = 3'd3;
         5'b00001: v = 3'd4;
         default:  v = 3'd0;
      endcase
      return v;
   endfunction

   biq_t       a_eff;
   logic [2:0] qa;
   logic [2:0] qb;
   logic [3:0] q_sum;
   logic       q_over;
   logic [2:0] q_res;
   logic [1:0] bi_cnt;

   // Reset add forces the accumulator side to zero
   assign a_eff = acc_zero ? BIQ_0 : a;

   assign digit_error = !(code_ok(a_eff) && code_ok(b));

   ////////////////////
   // Quinary half
   ////////////////////

   // The quinary sum runs 0 to 9, anything from 5 up passes a five to the bi half
   assign qa     = quin_value(a_eff[4:0]);
   assign qb     = quin_value(b[4:0]);
   assign q_sum  = {1'b0, qa} + {1'b0, qb} + {3'b000, carry_in};
   assign q_over = (q_sum >= 4'd5);
   assign q_res  = q_over ? 3'(q_sum - 4'd5) : q_sum[2:0];

   ////////////////////
   // Bi half
   ////////////////////

   // Count fives from both bi5 bits and the quinary overflow
   // Two fives make a decimal carry and the odd one is the bi5 of the result
   assign bi_cnt = {1'b0, a_eff[5]} + {1'b0, b[5]} + {1'b0, q_over};

   always_comb begin
      if (digit_error) begin
         sum       = BIQ_BLANK;
         carry_out = 1'b0;
      end else begin
         sum       = {~bi_cnt[0], bi_cnt[0], 5'b10000 >> q_res};
         carry_out = bi_cnt[1];
      end
   end

endmodule

`default_nettype wire

/* source/accumulator.sv */
`timescale 1ns/100ps
`default_nettype none

module accumulator import biq_pkg::*; (
   input  wire            ap,
   input  wire            rst,
   input  wire            load,
   input  wire biq_word_t word_in,
   input  wire            shift_en,
   input  wire biq_t      sum,
   output biq_t           low_digit,
   output biq_word_t      word_out
);

   biq_word_t word;

   // Digit 0 sits in the low bits and is the one presented to the adder
   assign low_digit = word[BIQ_W-1:0];
   assign word_out  = word;

   ////////////////////
   // Result register
   ////////////////////

   // Each shift drops the digit just added and puts its sum in at the top
   // After ten shifts every digit has been replaced and is back in place
   always_ff @(posedge ap) begin
      if (rst) begin
         // An empty accumulator holds ten zero digits, not blanks
         word <= {WORD_DIGITS{BIQ_0}};
      end else if (shift_en) begin
         word <= {sum, word[WORD_DIGITS*BIQ_W-1:BIQ_W]};
      end else if (load) begin
         word <= word_in;
      end
   end

endmodule

`default_nettype wire

/* source/distributor.sv */
`timescale 1ns/100ps
`default_nettype none

module distributor import biq_pkg::*; (
   input  wire            ap,
   input  wire            rst,
   input  wire            load,
   input  wire biq_word_t word_in,
   input  wire            shift_en,
   input  wire            ontime_clear,
   output biq_t           early,
   output biq_t           ontime,
   output logic           valid,
   output logic           not_blank
);

   biq_word_t word;

   // The early digit is the one at the low end of the word
   assign early = word[BIQ_W-1:0];

   // Check the early digit for one bit in each group and for blank
   assign valid     = $onehot(early[6:5]) && $onehot(early[4:0]);
   assign not_blank = |early;

   ////////////////////
   // Operand register
   ////////////////////

   // Rotate, so the operand survives the operation unchanged
   always_ff @(posedge ap) begin
      if (rst) begin
         word <= {WORD_DIGITS{BIQ_0}};
      end else if (shift_en) begin
         word <= {word[BIQ_W-1:0], word[WORD_DIGITS*BIQ_W-1:BIQ_W]};
      end else if (load) begin
         word <= word_in;
      end
   end

   // Delayed digit, one position behind early, gives the times ten path
   // Clearing it at the start feeds a zero into position 0
   always_ff @(posedge ap) begin
      if (rst) begin
         ontime <= BIQ_0;
      end else if (ontime_clear) begin
         ontime <= BIQ_0;
      end else if (shift_en) begin
         ontime <= early;
      end
   end

endmodule

`default_nettype wire

/* source/add_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module add_sequencer import biq_pkg::*; (
   input  wire      ap,
   input  wire      rst,
   input  wire      start,
   input  wire op_t op,
   input  wire      carry_out,
   input  wire      digit_error,
   output logic     busy,
   output logic     done,
   output logic     shift_en,
   output logic     ontime_clear,
   output logic     zero_entry,
   output logic     true_add_gate,
   output logic     compl_add_gate,
   output logic     ontime_add_gate,
   output logic     key_gate,
   output logic     acc_zero,
   output logic     carry_in,
   output logic     overflow,
   output logic     check_error
);

   seq_state_t state;
   digit_pos_t pos;
   op_t        op_q;
   logic       carry_q;
   logic       accept;
   logic       carry_init;
   logic       run;
   logic       first_pos;

   // A start only counts from idle, so one arriving while busy is lost
   assign accept     = (state == SEQ_IDLE) && start;
   // Tens complement needs the extra one in the lowest position
   assign carry_init = (op == OP_SUB);

   assign run       = (state == SEQ_RUN);
   assign first_pos = (pos == '0);

   assign busy         = (state != SEQ_IDLE);
   assign done         = (state == SEQ_FINISH);
   assign shift_en     = run;
   assign ontime_clear = accept;
   assign carry_in     = carry_q;

   ////////////////////
   // Control FSM
   ////////////////////

   // Idle, then ten run cycles for positions 0 to 9, then a single finish cycle
   always_ff @(posedge ap) begin
      if (rst) begin
         state       <= SEQ_IDLE;
         pos         <= '0;
         op_q        <= OP_ADD;
         carry_q     <= 1'b0;
         overflow    <= 1'b0;
         check_error <= 1'b0;
      end else begin
         case (state)
            SEQ_IDLE: begin
               if (accept) begin
                  state       <= SEQ_RUN;
                  pos         <= '0;
                  op_q        <= op;
                  carry_q     <= carry_init;
                  overflow    <= 1'b0;
                  check_error <= 1'b0;
               end
            end
            SEQ_RUN: begin
               carry_q <= carry_out;
               pos     <= pos + 1'b1;
               // Sticky over the whole word
               if (digit_error) begin
                  check_error <= 1'b1;
               end
               if (pos == LAST_DIGIT_POS) begin
                  state <= SEQ_FINISH;
                  // For subtract a missing final carry is a borrow
                  overflow <= (op_q == OP_SUB) ? ~carry_out : carry_out;
               end
            end
            SEQ_FINISH: begin
               state <= SEQ_IDLE;
            end
            default: begin
               state <= SEQ_IDLE;
            end
         endcase
      end
   end

   ////////////////////
   // Gate decode
   ////////////////////

   // At most one B path is open in a cycle, acc_zero only rides with true add
   always_comb begin
      zero_entry      = 1'b0;
      true_add_gate   = 1'b0;
      compl_add_gate  = 1'b0;
      ontime_add_gate = 1'b0;
      key_gate        = 1'b0;
      acc_zero        = 1'b0;
      if (run) begin
         case (op_q)
            OP_ADD:       true_add_gate   = 1'b1;
            OP_SUB:       compl_add_gate  = 1'b1;
            OP_SHIFT_ADD: ontime_add_gate = 1'b1;
            OP_RESET_ADD: begin
               true_add_gate = 1'b1;
               acc_zero      = 1'b1;
            end
            OP_ADD_KEY: begin
               // The key digit goes in at the units position only
               key_gate   = first_pos;
               zero_entry = !first_pos;
            end
            // Undefined codes just add zero and leave the word alone
            default:      zero_entry      = 1'b1;
         endcase
      end
   end

endmodule

`default_nettype wire

/* source/adder_top.sv */
`timescale 1ns/100ps
`default_nettype none

module adder_top import biq_pkg::*; (
   input  wire            ap,
   input  wire            rst,
   input  wire            load_acc,
   input  wire biq_word_t acc_in,
   input  wire            load_dist,
   input  wire biq_word_t dist_in,
   input  wire            start,
   input  wire op_t       op,
   input  wire key_t      key,
   output logic           busy,
   output logic           done,
   output logic           overflow,
   output logic           check_error,
   output biq_word_t      acc_out
);

   logic acc_load;
   logic dist_load;
   logic shift_en;
   logic ontime_clear;
   logic zero_entry;
   logic true_add_gate;
   logic compl_add_gate;
   logic ontime_add_gate;
   logic key_gate;
   logic acc_zero;
   logic carry_in;
   logic carry_out;
   logic digit_error;
   logic dist_valid;
   logic dist_not_blank;
   biq_t dist_early;
   biq_t dist_ontime;
   biq_t acc_digit;
   biq_t entry_b;
   biq_t sum;

   // Registers are locked against loads while an operation is running
   assign acc_load  = load_acc & ~busy;
   assign dist_load = load_dist & ~busy;

   add_sequencer seq_i (
      .ap              (ap),
      .rst             (rst),
      .start           (start),
      .op              (op),
      .carry_out       (carry_out),
      .digit_error     (digit_error),
      .busy            (busy),
      .done            (done),
      .shift_en        (shift_en),
      .ontime_clear    (ontime_clear),
      .zero_entry      (zero_entry),
      .true_add_gate   (true_add_gate),
      .compl_add_gate  (compl_add_gate),
      .ontime_add_gate (ontime_add_gate),
      .key_gate        (key_gate),
      .acc_zero        (acc_zero),
      .carry_in        (carry_in),
      .overflow        (overflow),
      .check_error     (check_error)
   );

   distributor dist_i (
      .ap           (ap),
      .rst          (rst),
      .load         (dist_load),
      .word_in      (dist_in),
      .shift_en     (shift_en),
      .ontime_clear (ontime_clear),
      .early        (dist_early),
      .ontime       (dist_ontime),
      .valid        (dist_valid),
      .not_blank    (dist_not_blank)
   );

   accumulator acc_i (
      .ap        (ap),
      .rst       (rst),
      .load      (acc_load),
      .word_in   (acc_in),
      .shift_en  (shift_en),
      .sum       (sum),
      .low_digit (acc_digit),
      .word_out  (acc_out)
   );

   add_in_b in_b_i (
      .dist_early      (dist_early),
      .dist_ontime     (dist_ontime),
      .key             (key),
      .key_gate        (key_gate),
      .ontime_add_gate (ontime_add_gate),
      .compl_add_gate  (compl_add_gate),
      .dist_valid      (dist_valid),
      .dist_not_blank  (dist_not_blank),
      .zero_entry      (zero_entry),
      .true_add_gate   (true_add_gate),
      .entry_b         (entry_b)
   );

   biq_digit_adder adder_i (
      .a           (acc_digit),
      .b           (entry_b),
      .acc_zero    (acc_zero),
      .carry_in    (carry_in),
      .sum         (sum),
      .carry_out   (carry_out),
      .digit_error (digit_error)
   );

endmodule

`default_nettype wire

/* testbench/adder_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module adder_asserts (
   input wire ap,
   input wire rst,
   input wire busy,
   input wire done,
   input wire zero_entry,
   input wire true_add_gate,
   input wire compl_add_gate,
   input wire ontime_add_gate,
   input wire key_gate
);

   ////////////////////
   // Sequencer checks
   ////////////////////

   // The done strobe is a single cycle pulse
   done_one_cycle: assert property (@(posedge ap) disable iff (rst) done |=> !done)
      else $error("done stayed high for more than one cycle");

   // Only one path may drive the B side of the adder at a time
   gates_exclusive: assert property (@(posedge ap) disable iff (rst)
      $onehot0({zero_entry, true_add_gate, compl_add_gate, ontime_add_gate, key_gate}))
      else $error("more than one adder B gate open in the same cycle");

   // A synchronous reset leaves the sequencer idle
   idle_after_reset: assert property (@(posedge ap) rst |=> !busy && !done)
      else $error("busy or done high after reset");

endmodule

`default_nettype wire

/* testbench/adder_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module adder_tb import biq_pkg::*; ();

   ////////////////////
   // Timing and sizes
   ////////////////////

   localparam int CLK_PERIOD    = 40;
   localparam int RESET_CYCLES  = 5;
   localparam int LATENCY       = 11;
   localparam int MAX_WAIT      = 20;
   // Cycle within a run where the disturbing start and loads are driven
   localparam int DISTURB_CYCLE = 5;
   localparam int N_FIXED       = 14;
   localparam int N_RANDOM      = 8;
   localparam int N_ROWS        = N_FIXED + N_RANDOM;
   localparam int WATCHDOG_CYC  = N_ROWS * 15 + RESET_CYCLES;

   localparam longint TEN      = 64'd10;
   localparam longint WORD_MOD = 64'd10000000000;

   // Codes for the checking rows
   // Both bi bits set makes a malformed code
   localparam biq_t BLANK_CODE = 7'b00_00000;
   localparam biq_t BAD_MIXED  = 7'b11_10000;

   logic      ap;
   logic      rst;
   logic      load_acc;
   biq_word_t acc_in;
   logic      load_dist;
   biq_word_t dist_in;
   logic      start;
   op_t       op;
   key_t      key;
   logic      busy;
   logic      done;
   logic      overflow;
   logic      check_error;
   biq_word_t acc_out;

   // Stimulus and expected values with one row per test
   op_t    row_op      [N_ROWS];
   longint row_acc     [N_ROWS];
   longint row_dist    [N_ROWS];
   int     row_key     [N_ROWS];
   longint row_exp     [N_ROWS];
   bit     row_ovf     [N_ROWS];
   bit     row_err     [N_ROWS];
   int     row_bad_pos [N_ROWS];
   biq_t   row_bad     [N_ROWS];
   bit     row_disturb [N_ROWS];

   int     n_rows     = 0;
   int     n_failed   = 0;
   integer seed       = 65994;

   adder_top adder_top_i (
      .ap          (ap),
      .rst         (rst),
      .load_acc    (load_acc),
      .acc_in      (acc_in),
      .load_dist   (load_dist),
      .dist_in     (dist_in),
      .start       (start),
      .op          (op),
      .key         (key),
      .busy        (busy),
      .done        (done),
      .overflow    (overflow),
      .check_error (check_error),
      .acc_out     (acc_out)
   );

   bind add_sequencer adder_asserts seq_asserts_i (
      .ap              (ap),
      .rst             (rst),
      .busy            (busy),
      .done            (done),
      .zero_entry      (zero_entry),
      .true_add_gate   (true_add_gate),
      .compl_add_gate  (compl_add_gate),
      .ontime_add_gate (ontime_add_gate),
      .key_gate        (key_gate)
   );

   always #(CLK_PERIOD / 2) ap = ~ap;

   ////////////////////
   // Helpers
   ////////////////////

   // One decimal digit as bi-quinary with bi5 set for 5 to 9
   function automatic biq_t digit_code(input int d);
      biq_t c;
      c[6:5] = (d >= 5) ? 2'b01 : 2'b10;
      c[4:0] = 5'b10000 >> (d % 5);
      return c;
   endfunction

   // Decimal value to a ten digit word with the units digit in the low bits
   function automatic biq_word_t to_biq(input longint value);
      biq_word_t w;
      longint    v;
      v = value;
      for (int i = 0; i < WORD_DIGITS; i++) begin
         w[i*BIQ_W +: BIQ_W] = digit_code(int'(v % TEN));
         v = v / TEN;
      end
      return w;
   endfunction

   function automatic key_t key_line(input int k);
      return key_t'(1) << k;
   endfunction

   function automatic int rand_below(input int n);
      int r;
      r = $random(seed);
      return ((r % n) + n) % n;
   endfunction

   function automatic longint rand_word();
      longint v;
      v = 64'd0;
      for (int i = 0; i < WORD_DIGITS; i++) begin
         v = v * TEN + longint'(rand_below(10));
      end
      return v;
   endfunction

   // Decimal model of the five operations with all results modulo ten to the tenth
   function automatic longint model_result(input op_t o, input longint a, input longint d,
                                           input int k, output bit ovf);
      longint t;
      ovf = 1'b0;
      case (o)
         OP_ADD:       t = a + d;
         OP_SUB: begin
            // A borrow out of the top digit is the overflow
            t = a - d;
            if (t < 64'd0) begin
               t   = t + WORD_MOD;
               ovf = 1'b1;
            end
         end
         OP_SHIFT_ADD: t = a + (d % (WORD_MOD / TEN)) * TEN;
         OP_RESET_ADD: t = d;
         OP_ADD_KEY:   t = a + longint'(k);
         default:      t = a;
      endcase
      if (o != OP_SUB && t >= WORD_MOD) begin
         t   = t - WORD_MOD;
         ovf = 1'b1;
      end
      return t;
   endfunction

   task automatic add_row(input op_t o, input longint a, input longint d, input int k,
                          input longint e, input bit ovf, input bit err, input int bad_pos,
                          input biq_t bad, input bit disturb);
      row_op[n_rows]      = o;
      row_acc[n_rows]     = a;
      row_dist[n_rows]    = d;
      row_key[n_rows]     = k;
      row_exp[n_rows]     = e;
      row_ovf[n_rows]     = ovf;
      row_err[n_rows]     = err;
      row_bad_pos[n_rows] = bad_pos;
      row_bad[n_rows]     = bad;
      row_disturb[n_rows] = disturb;
      n_rows++;
   endtask

   task automatic fill_table();
      op_t    o;
      longint a;
      longint d;
      longint e;
      int     k;
      bit     ovf;
      // Add with the all nines edge case
      add_row(OP_ADD, 64'd9999999999, 64'd1, 0, 64'd0, 1'b1, 1'b0, -1, BLANK_CODE, 1'b0);
      add_row(OP_ADD, 64'd1234567890, 64'd987654321, 0, 64'd2222222211,
              1'b0, 1'b0, -1, BLANK_CODE, 1'b0);
      // Subtract borrows exactly when D is larger
      add_row(OP_SUB, 64'd5000000000, 64'd1234567891, 0, 64'd3765432109,
              1'b0, 1'b0, -1, BLANK_CODE, 1'b0);
      add_row(OP_SUB, 64'd100, 64'd250, 0, 64'd9999999850, 1'b1, 1'b0, -1, BLANK_CODE, 1'b0);
      add_row(OP_SUB, 64'd42, 64'd42, 0, 64'd0, 1'b0, 1'b0, -1, BLANK_CODE, 1'b0);
      // Shift add drops the top distributor digit
      add_row(OP_SHIFT_ADD, 64'd1111111111, 64'd9876543210, 0, 64'd9876543211,
              1'b0, 1'b0, -1, BLANK_CODE, 1'b0);
      add_row(OP_SHIFT_ADD, 64'd5000000000, 64'd500000000, 0, 64'd0,
              1'b1, 1'b0, -1, BLANK_CODE, 1'b0);
      add_row(OP_RESET_ADD, 64'd7777777777, 64'd123, 0, 64'd123,
              1'b0, 1'b0, -1, BLANK_CODE, 1'b0);
      add_row(OP_ADD_KEY, 64'd999999999, 64'd0, 7, 64'd1000000006,
              1'b0, 1'b0, -1, BLANK_CODE, 1'b0);
      add_row(OP_ADD_KEY, 64'd9999999999, 64'd0, 1, 64'd0, 1'b1, 1'b0, -1, BLANK_CODE, 1'b0);
      // A bad top distributor digit leaves a blank result digit in that place
      add_row(OP_ADD, 64'd1234567890, 64'd111111111, 0, 64'd345679001,
              1'b0, 1'b1, 9, BLANK_CODE, 1'b0);
      add_row(OP_ADD, 64'd1234567890, 64'd111111111, 0, 64'd345679001,
              1'b0, 1'b1, 9, BAD_MIXED, 1'b0);
      // A clean operation after the bad ones clears check_error
      add_row(OP_ADD, 64'd1, 64'd2, 0, 64'd3, 1'b0, 1'b0, -1, BLANK_CODE, 1'b0);
      // Start and loads are driven in the middle of this run
      add_row(OP_ADD, 64'd5555555555, 64'd4444444444, 0, 64'd9999999999,
              1'b0, 1'b0, -1, BLANK_CODE, 1'b1);
      for (int i = 0; i < N_RANDOM; i++) begin
         o = op_t'(rand_below(5));
         a = rand_word();
         d = rand_word();
         k = rand_below(10);
         e = model_result(o, a, d, k, ovf);
         add_row(o, a, d, k, e, ovf, 1'b0, -1, BLANK_CODE, 1'b0);
      end
   endtask

   ////////////////////
   // One test
   ////////////////////

   task automatic run_row(input int idx);
      biq_word_t dist_word;
      biq_word_t exp_word;
      int        cycles;
      bit        got;
      bit        bad;
      dist_word = to_biq(row_dist[idx]);
      exp_word  = to_biq(row_exp[idx]);
      bad       = 1'b0;
      if (row_bad_pos[idx] >= 0) begin
         dist_word[row_bad_pos[idx]*BIQ_W +: BIQ_W] = row_bad[idx];
         exp_word[row_bad_pos[idx]*BIQ_W +: BIQ_W]  = BLANK_CODE;
      end
      @(negedge ap);
      load_acc  = 1'b1;
      acc_in    = to_biq(row_acc[idx]);
      load_dist = 1'b1;
      dist_in   = dist_word;
      @(negedge ap);
      load_acc  = 1'b0;
      load_dist = 1'b0;
      start     = 1'b1;
      op        = row_op[idx];
      key       = key_line(row_key[idx]);
      cycles    = 0;
      got       = 1'b0;
      while (!got && cycles < MAX_WAIT) begin
         @(negedge ap);
         cycles++;
         if (cycles == 1) begin
            start = 1'b0;
         end
         if (row_disturb[idx] && cycles == DISTURB_CYCLE) begin
            load_acc  = 1'b1;
            acc_in    = to_biq(64'd1111111111);
            load_dist = 1'b1;
            dist_in   = to_biq(64'd2222222222);
            op        = OP_RESET_ADD;
            start     = 1'b1;
         end
         if (row_disturb[idx] && cycles == DISTURB_CYCLE + 1) begin
            load_acc  = 1'b0;
            load_dist = 1'b0;
            start     = 1'b0;
         end
         if (done) begin
            got = 1'b1;
         end else if (!busy) begin
            $display("Test %0d: busy went low before done, in cycle %0d", idx, cycles);
            bad = 1'b1;
            break;
         end
      end
      if (!got) begin
         $display("Test %0d: done did not arrive within %0d cycles of start", idx, cycles);
         bad = 1'b1;
      end else begin
         if (cycles != LATENCY) begin
            $display("Mismatch at %0t: done latency expected %0d, got %0d",
                     $time, LATENCY, cycles);
            bad = 1'b1;
         end
         if (acc_out !== exp_word) begin
            $display("Mismatch at %0t: acc_out expected %h, got %h", $time, exp_word, acc_out);
            bad = 1'b1;
         end
         if (overflow !== row_ovf[idx]) begin
            $display("Mismatch at %0t: overflow expected %0b, got %0b",
                     $time, row_ovf[idx], overflow);
            bad = 1'b1;
         end
         if (check_error !== row_err[idx]) begin
            $display("Mismatch at %0t: check_error expected %0b, got %0b",
                     $time, row_err[idx], check_error);
            bad = 1'b1;
         end
      end
      if (bad) begin
         n_failed++;
      end
      $display("Test %0d op %0d: %s", idx, row_op[idx], bad ? "FAILED" : "ok");
      // Let the finish cycle pass before the next test begins
      @(negedge ap);
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      ap        = 1'b0;
      rst       = 1'b1;
      load_acc  = 1'b0;
      acc_in    = '0;
      load_dist = 1'b0;
      dist_in   = '0;
      start     = 1'b0;
      op        = OP_ADD;
      key       = '0;
      fill_table();
      repeat (RESET_CYCLES) @(negedge ap);
      rst = 1'b0;
      for (int i = 0; i < n_rows; i++) begin
         run_row(i);
      end
      $display("Summary: %0d tests, %0d passed, %0d failed", n_rows, n_rows - n_failed,
               n_failed);
      if (n_failed == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   // Watchdog sized from the row count
   initial begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("Timeout: the run did not end within %0d cycles", WATCHDOG_CYC);
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
source/biq_pkg.sv
source/biq_9s_comp.sv
source/add_in_b.sv
source/biq_digit_adder.sv
source/accumulator.sv
source/distributor.sv
source/add_sequencer.sv
source/adder_top.sv
testbench/adder_asserts.sv
testbench/adder_tb.sv

/* Makefile */
# Verilator build and run of the bi-quinary adder testbench
# Any variable can be overridden on the command line, e.g. make sim TOP=adder_tb

VERILATOR ?= verilator
TOP       ?= adder_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Testbench passed

.PHONY: sim clean

# Build, run, and decide pass or fail by searching the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
